//--- source/dma_settings.svh
`ifndef DMA_SETTINGS_SVH
`define DMA_SETTINGS_SVH

// Data word width in bits
`define DMA_DATA_W 32

// Byte address width
`define DMA_ADDR_W 32

// Burst length field, bursts of up to 2**DMA_LEN_W beats
`define DMA_LEN_W 4

// Command queue holds 2**DMA_CMD_AW entries
`define DMA_CMD_AW 2

// Data buffer holds 2**DMA_BUF_AW words
`define DMA_BUF_AW 6

`endif

//--- source/dma_pkg.sv
`include "dma_settings.svh"

package dma_pkg;

    typedef logic [`DMA_DATA_W-1:0] dma_data_t;
    typedef logic [`DMA_ADDR_W-1:0] dma_addr_t;

    // Words per command
    typedef logic [15:0] dma_words_t;

    // AXI len field, beats minus one
    typedef logic [`DMA_LEN_W-1:0] dma_blen_t;

    // Beats per burst, one bit wider to hold the full count
    typedef logic [`DMA_LEN_W:0] dma_bcnt_t;

    typedef logic [1:0] dma_resp_t;

    typedef enum logic [1:0] {
        st_idle,
        st_wait_credit,
        st_issue,
        st_next
    } dma_split_state_t;

endpackage

//--- source/dma_ifs.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

// Command handoff from queue to splitter
interface dma_cmd_if;
    import dma_pkg::*;

    logic       valid;
    logic       ready;
    dma_addr_t  addr;
    dma_words_t words;

    modport source (output valid, output addr, output words, input ready);
    modport sink (input valid, input addr, input words, output ready);
endinterface

// Buffer space reservation between splitter and collector
interface dma_credit_if;
    import dma_pkg::*;

    logic      reserve;
    dma_bcnt_t count;
    logic      last_of_cmd;
    logic      okay;

    modport requester (
        output reserve, output count, output last_of_cmd,
        input okay
    );
    modport provider (
        input reserve, input count, input last_of_cmd,
        output okay
    );
endinterface

//--- source/dma_cmd_queue.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_cmd_queue (
    input  logic                clk,
    input  logic                rst,
    input  logic                push,
    input  dma_pkg::dma_addr_t  addr,
    input  dma_pkg::dma_words_t words,
    output logic                full,
    output logic                almost_empty,
    output logic                empty,
    dma_cmd_if.source           cmd
);
    import dma_pkg::*;

    localparam int depth = 2 ** `DMA_CMD_AW;

    dma_addr_t              addr_mem [depth];
    dma_words_t             words_mem [depth];
    logic [`DMA_CMD_AW-1:0] wr_ptr;
    logic [`DMA_CMD_AW-1:0] rd_ptr;
    logic [`DMA_CMD_AW:0]   count;
    logic                   do_push;
    logic                   do_pop;

    // Empty commands never enter the queue
    assign do_push = push && !full && (words != '0);
    assign do_pop = cmd.valid && cmd.ready;

    assign full = (count == (`DMA_CMD_AW+1)'(depth));
    assign empty = (count == '0);
    assign almost_empty = (count <= (`DMA_CMD_AW+1)'(1));

    assign cmd.valid = !empty;
    assign cmd.addr = addr_mem[rd_ptr];
    assign cmd.words = words_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            addr_mem[wr_ptr] <= addr;
            words_mem[wr_ptr] <= words;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + (`DMA_CMD_AW)'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + (`DMA_CMD_AW)'(1);
            end
            case ({do_push, do_pop})
                2'b10: count <= count + (`DMA_CMD_AW+1)'(1);
                2'b01: count <= count - (`DMA_CMD_AW+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/dma_burst_splitter.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_burst_splitter (
    input  logic               clk,
    input  logic               rst,
    input  logic               halt,
    dma_cmd_if.sink            cmd,
    dma_credit_if.requester    credit,
    output logic               ar_valid,
    input  logic               ar_ready,
    output dma_pkg::dma_addr_t ar_addr,
    output dma_pkg::dma_blen_t ar_len,
    output logic               idle
);
    import dma_pkg::*;

    localparam int lsb = $clog2(`DMA_DATA_W / 8);
    localparam dma_bcnt_t max_beats = dma_bcnt_t'(2 ** `DMA_LEN_W);

    dma_split_state_t state;
    dma_addr_t        cur_addr;
    dma_words_t       remaining;
    dma_bcnt_t        beats;
    logic             cmd_take;

    // Largest burst that still fits in the command
    assign beats = (remaining > dma_words_t'(max_beats)) ? max_beats
                                                         : dma_bcnt_t'(remaining);

    assign idle = (state == st_idle);
    assign cmd.ready = idle;
    assign cmd_take = cmd.valid && cmd.ready;

    assign credit.count = beats;
    assign credit.last_of_cmd = (dma_words_t'(beats) == remaining);
    // Halt only blocks a burst that has not yet reserved space
    assign credit.reserve = (state == st_wait_credit) && credit.okay && !halt;

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            ar_valid <= 1'b0;
        end else begin
            case (state)
                st_idle: begin
                    if (cmd_take) begin
                        state <= st_wait_credit;
                    end
                end
                st_wait_credit: begin
                    if (credit.reserve) begin
                        ar_valid <= 1'b1;
                        state <= st_issue;
                    end
                end
                st_issue: begin
                    if (ar_ready) begin
                        ar_valid <= 1'b0;
                        state <= st_next;
                    end
                end
                st_next: begin
                    state <= (remaining == '0) ? st_idle : st_wait_credit;
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state)
            st_idle: begin
                if (cmd_take) begin
                    cur_addr <= cmd.addr;
                    remaining <= cmd.words;
                end
            end
            st_wait_credit: begin
                if (credit.reserve) begin
                    ar_addr <= cur_addr;
                    ar_len <= dma_blen_t'(beats - dma_bcnt_t'(1));
                end
            end
            st_issue: begin
                // Step past the burst once the slave has it
                if (ar_ready) begin
                    cur_addr <= cur_addr + (dma_addr_t'(beats) << lsb);
                    remaining <= remaining - dma_words_t'(beats);
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- source/dma_read_collector.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_read_collector (
    input  logic               clk,
    input  logic               rst,
    dma_credit_if.provider     credit,
    input  logic               pop_done,
    input  logic               r_valid,
    input  logic               r_last,
    input  dma_pkg::dma_data_t r_data,
    input  dma_pkg::dma_resp_t r_resp,
    output logic               r_ready,
    output logic               wr_push,
    output dma_pkg::dma_data_t wr_data,
    output dma_pkg::dma_resp_t error,
    output logic               cmd_done,
    output logic               outstanding
);
    import dma_pkg::*;

    localparam int tag_depth = 2 ** `DMA_BUF_AW;

    logic [`DMA_BUF_AW:0]   free_cnt;
    logic [`DMA_BUF_AW:0]   res_cnt;
    logic [`DMA_BUF_AW:0]   ret_cnt;
    logic                   pop_r;
    logic                   beat;
    logic                   drop;
    logic                   burst_end;
    logic                   tag_mem [tag_depth];
    logic [`DMA_BUF_AW-1:0] tag_wr;
    logic [`DMA_BUF_AW-1:0] tag_rd;
    logic [`DMA_BUF_AW:0]   tag_cnt;

    assign res_cnt = {{(`DMA_BUF_AW-`DMA_LEN_W){1'b0}}, credit.count};
    assign credit.okay = (free_cnt >= res_cnt);

    assign beat = r_valid && r_ready;
    assign burst_end = beat && r_last;
    assign wr_push = beat && (r_resp == 2'b00) && (error == 2'b00);
    assign wr_data = r_data;
    // Dropped beats give their reserved word back at once
    assign drop = beat && !wr_push;
    assign ret_cnt = {{`DMA_BUF_AW{1'b0}}, pop_r} + {{`DMA_BUF_AW{1'b0}}, drop};

    assign outstanding = (tag_cnt != '0);

    always_ff @(posedge clk) begin
        if (credit.reserve) begin
            tag_mem[tag_wr] <= credit.last_of_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            free_cnt <= {1'b1, {`DMA_BUF_AW{1'b0}}};
            pop_r <= 1'b0;
            r_ready <= 1'b0;
            error <= 2'b00;
            cmd_done <= 1'b0;
            tag_wr <= '0;
            tag_rd <= '0;
            tag_cnt <= '0;
        end else begin
            r_ready <= 1'b1;
            pop_r <= pop_done;
            free_cnt <= (credit.reserve ? free_cnt - res_cnt : free_cnt) + ret_cnt;
            // First error sticks
            if (beat && (r_resp != 2'b00) && (error == 2'b00)) begin
                error <= r_resp;
            end
            cmd_done <= burst_end && tag_mem[tag_rd];
            if (credit.reserve) begin
                tag_wr <= tag_wr + (`DMA_BUF_AW)'(1);
            end
            if (burst_end) begin
                tag_rd <= tag_rd + (`DMA_BUF_AW)'(1);
            end
            tag_cnt <= tag_cnt + {{`DMA_BUF_AW{1'b0}}, credit.reserve}
                               - {{`DMA_BUF_AW{1'b0}}, burst_end};
        end
    end

endmodule

//--- source/dma_data_buffer.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module dma_data_buffer (
    input  logic               clk,
    input  logic               rst,
    input  logic               wr_push,
    input  dma_pkg::dma_data_t wr_data,
    input  logic               pop,
    output dma_pkg::dma_data_t rd_data,
    output logic               rd_valid
);
    import dma_pkg::*;

    localparam int depth = 2 ** `DMA_BUF_AW;

    dma_data_t              mem [depth];
    logic [`DMA_BUF_AW-1:0] wr_ptr;
    logic [`DMA_BUF_AW-1:0] rd_ptr;
    logic [`DMA_BUF_AW:0]   count;
    logic                   do_pop;

    assign rd_valid = (count != '0);
    assign rd_data = mem[rd_ptr];
    assign do_pop = pop && rd_valid;

    always_ff @(posedge clk) begin
        if (wr_push) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // No full check, upstream credit bounds the fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count <= '0;
        end else begin
            if (wr_push) begin
                wr_ptr <= wr_ptr + (`DMA_BUF_AW)'(1);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + (`DMA_BUF_AW)'(1);
            end
            case ({wr_push, do_pop})
                2'b10: count <= count + (`DMA_BUF_AW+1)'(1);
                2'b01: count <= count - (`DMA_BUF_AW+1)'(1);
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/dma_read_top.sv
`timescale 1ns/10ps

module dma_read_top (
    input  logic                clk,
    input  logic                rst,
    input  logic                cmd_push,
    input  dma_pkg::dma_addr_t  cmd_addr,
    input  dma_pkg::dma_words_t cmd_words,
    output logic                cmd_almost_empty,
    output logic                cmd_full,
    input  logic                halt,
    output logic                busy,
    output logic                cmd_done,
    output dma_pkg::dma_resp_t  error,
    output logic                ar_valid,
    input  logic                ar_ready,
    output dma_pkg::dma_addr_t  ar_addr,
    output dma_pkg::dma_blen_t  ar_len,
    input  logic                r_valid,
    output logic                r_ready,
    input  logic                r_last,
    input  dma_pkg::dma_data_t  r_data,
    input  dma_pkg::dma_resp_t  r_resp,
    input  logic                out_pop,
    output dma_pkg::dma_data_t  out_data,
    output logic                out_valid
);
    import dma_pkg::*;

    logic      cmd_empty;
    logic      split_idle;
    logic      outstanding;
    logic      pop_done;
    logic      wr_push;
    dma_data_t wr_data;

    dma_cmd_if    cmd_bus ();
    dma_credit_if credit_bus ();

    // Work is pending anywhere along the pipeline
    assign busy = !cmd_empty || !split_idle || outstanding;
    assign pop_done = out_pop && out_valid;

    dma_cmd_queue u_queue (
        .clk          (clk),
        .rst          (rst),
        .push         (cmd_push),
        .addr         (cmd_addr),
        .words        (cmd_words),
        .full         (cmd_full),
        .almost_empty (cmd_almost_empty),
        .empty        (cmd_empty),
        .cmd          (cmd_bus.source)
    );

    dma_burst_splitter u_splitter (
        .clk      (clk),
        .rst      (rst),
        .halt     (halt),
        .cmd      (cmd_bus.sink),
        .credit   (credit_bus.requester),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .idle     (split_idle)
    );

    dma_read_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .credit      (credit_bus.provider),
        .pop_done    (pop_done),
        .r_valid     (r_valid),
        .r_last      (r_last),
        .r_data      (r_data),
        .r_resp      (r_resp),
        .r_ready     (r_ready),
        .wr_push     (wr_push),
        .wr_data     (wr_data),
        .error       (error),
        .cmd_done    (cmd_done),
        .outstanding (outstanding)
    );

    dma_data_buffer u_buffer (
        .clk      (clk),
        .rst      (rst),
        .wr_push  (wr_push),
        .wr_data  (wr_data),
        .pop      (out_pop),
        .rd_data  (out_data),
        .rd_valid (out_valid)
    );

endmodule

//--- bench/axi_read_model.sv
`timescale 1ns/10ps

// Read slave that answers each beat with the inverted byte address
module axi_read_model (
    input  logic               clk,
    input  logic               rst,
    input  logic               ar_valid,
    output logic               ar_ready,
    input  dma_pkg::dma_addr_t ar_addr,
    input  dma_pkg::dma_blen_t ar_len,
    output logic               r_valid,
    input  logic               r_ready,
    output logic               r_last,
    output dma_pkg::dma_data_t r_data,
    output dma_pkg::dma_resp_t r_resp,
    input  dma_pkg::dma_addr_t err_addr
);
    import dma_pkg::*;

    dma_addr_t burst_addr [$];
    int        burst_beats [$];
    dma_addr_t cur_addr;
    int        cur_left;
    logic      ar_taken;
    logic      r_taken;

    initial begin
        ar_ready = 1'b0;
        r_valid = 1'b0;
        r_last = 1'b0;
        r_data = '0;
        r_resp = 2'b00;
        cur_addr = '0;
        cur_left = 0;
        ar_taken = 1'b0;
        r_taken = 1'b0;
    end

    // Handshakes sampled mid-cycle
    always @(negedge clk) begin
        ar_taken = ar_valid && ar_ready;
        r_taken = r_valid && r_ready;
        if (ar_taken) begin
            burst_addr.push_back(ar_addr);
            burst_beats.push_back(int'(ar_len) + 1);
        end
    end

    always @(posedge clk) begin
        #1;
        if (rst) begin
            ar_ready = 1'b0;
            r_valid = 1'b0;
            r_last = 1'b0;
            cur_left = 0;
            burst_addr.delete();
            burst_beats.delete();
        end else begin
            ar_ready = (($urandom % 4) != 0);
            if (r_taken) begin
                cur_addr = cur_addr + dma_addr_t'(4);
                cur_left--;
                r_valid = 1'b0;
            end
            if (cur_left == 0 && burst_addr.size() != 0) begin
                cur_addr = burst_addr.pop_front();
                cur_left = burst_beats.pop_front();
            end
            // A presented beat holds until taken
            if (!r_valid && cur_left != 0 && (($urandom % 3) != 0)) begin
                r_valid = 1'b1;
                r_last = (cur_left == 1);
                r_data = ~cur_addr;
                r_resp = (err_addr != '0 && cur_addr == err_addr) ? 2'b10 : 2'b00;
            end
        end
    end

endmodule

//--- bench/tb_dma_read.sv
`timescale 1ns/10ps
`include "dma_settings.svh"

module tb_dma_read;
    import dma_pkg::*;

    localparam int buf_words = 2 ** `DMA_BUF_AW;
    localparam int max_beats = 2 ** `DMA_LEN_W;
    localparam int halt_cmd = 2;
    localparam int step_limit = 20000;

    logic       clk = 1'b0;
    logic       rst;
    logic       cmd_push;
    dma_addr_t  cmd_addr;
    dma_words_t cmd_words;
    logic       cmd_almost_empty;
    logic       cmd_full;
    logic       halt;
    logic       busy;
    logic       cmd_done;
    dma_resp_t  error;
    logic       ar_valid;
    logic       ar_ready;
    dma_addr_t  ar_addr;
    dma_blen_t  ar_len;
    logic       r_valid;
    logic       r_ready;
    logic       r_last;
    dma_data_t  r_data;
    dma_resp_t  r_resp;
    logic       out_pop;
    dma_data_t  out_data;
    logic       out_valid;
    dma_addr_t  err_addr;

    // Reference model state
    dma_data_t  exp_data [$];
    dma_addr_t  exp_ar_addr [$];
    dma_blen_t  exp_ar_len [$];
    logic       err_hit;
    int         requested;
    int         popped;
    int         dropped;
    int         done_cnt;
    int         ar_cnt;
    logic       halt_prev;
    logic       halt_allow;

    always #50 clk = ~clk;

    dma_read_top DUT (.*);

    axi_read_model u_slave (
        .clk      (clk),
        .rst      (rst),
        .ar_valid (ar_valid),
        .ar_ready (ar_ready),
        .ar_addr  (ar_addr),
        .ar_len   (ar_len),
        .r_valid  (r_valid),
        .r_ready  (r_ready),
        .r_last   (r_last),
        .r_data   (r_data),
        .r_resp   (r_resp),
        .err_addr (err_addr)
    );

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display(">>> FAIL");
        $fatal(1, "run aborted");
    endtask

    // Expected data and bursts of one command
    task automatic load_expect(input dma_addr_t addr, input int words, input dma_addr_t bad);
        dma_addr_t a;
        int        rem;
        int        n;
        for (int i = 0; i < words; i++) begin
            a = addr + dma_addr_t'(4 * i);
            if (bad != '0 && a == bad) begin
                err_hit = 1'b1;
            end
            if (!err_hit) begin
                exp_data.push_back(~a);
            end
        end
        a = addr;
        rem = words;
        while (rem > 0) begin
            n = (rem > max_beats) ? max_beats : rem;
            exp_ar_addr.push_back(a);
            exp_ar_len.push_back(dma_blen_t'(n - 1));
            a = a + dma_addr_t'(4 * n);
            rem = rem - n;
        end
    endtask

    always @(negedge clk) begin
        if (!rst) begin
            if (halt && !halt_prev) begin
                halt_allow = ar_valid;
            end
            if (ar_valid && ar_ready) begin
                assert (!halt || halt_allow)
                else abort_run("new read burst accepted while halt was high");
                halt_allow = 1'b0;
                assert (exp_ar_addr.size() != 0)
                else abort_run("unexpected burst on the read address channel");
                assert (ar_addr == exp_ar_addr[0])
                else abort_run($sformatf("error ar_addr %h expected %h", ar_addr, exp_ar_addr[0]));
                assert (ar_len == exp_ar_len[0])
                else abort_run($sformatf("error ar_len %h expected %h", ar_len, exp_ar_len[0]));
                void'(exp_ar_addr.pop_front());
                void'(exp_ar_len.pop_front());
                requested += int'(ar_len) + 1;
                ar_cnt++;
            end
            if (r_valid && r_ready && (r_resp != 2'b00 || error != 2'b00)) begin
                dropped++;
            end
            if (out_pop && out_valid) begin
                popped++;
            end
            if (cmd_done) begin
                done_cnt++;
            end
            assert (requested - popped - dropped <= buf_words)
            else abort_run($sformatf("error words in flight %h exceed %h",
                                     requested - popped - dropped, buf_words));
            halt_prev = halt;
        end
    end

    task automatic consume_words(input int count, input int stall);
        int got;
        int cycles;
        got = 0;
        cycles = 0;
        while (got < count) begin
            @(posedge clk);
            #1;
            out_pop = (($urandom % 100) >= stall);
            @(negedge clk);
            if (out_pop && out_valid) begin
                assert (out_data == exp_data[0])
                else abort_run($sformatf("error out_data %h expected %h", out_data, exp_data[0]));
                void'(exp_data.pop_front());
                got++;
            end
            cycles++;
            assert (cycles < step_limit) else abort_run("timeout waiting for consumer data");
        end
        @(posedge clk);
        #1;
        out_pop = 1'b0;
    endtask

    task automatic wait_done(input int target);
        int cycles;
        cycles = 0;
        while (done_cnt < target) begin
            @(negedge clk);
            cycles++;
            assert (cycles < step_limit) else abort_run("timeout waiting for cmd_done");
        end
    endtask

    task automatic wait_idle();
        int cycles;
        cycles = 0;
        while (busy) begin
            @(negedge clk);
            cycles++;
            assert (cycles < step_limit) else abort_run("timeout waiting for busy to fall");
        end
    endtask

    // Hold halt across the later bursts of a command
    task automatic pulse_halt(input int hs_before);
        int cycles;
        cycles = 0;
        while (ar_cnt == hs_before) begin
            @(negedge clk);
            cycles++;
            assert (cycles < step_limit) else abort_run("timeout waiting for a burst before halt");
        end
        @(posedge clk);
        #1;
        halt = 1'b1;
        repeat (40) @(posedge clk);
        #1;
        halt = 1'b0;
    endtask

    initial begin
        int         fd;
        int         fields;
        string      line;
        dma_addr_t  addr;
        dma_addr_t  bad;
        dma_words_t words;
        int         stall;
        int         idx;
        int         done_before;
        int         hs_before;
        void'($urandom(32'h620492c0));
        rst = 1'b1;
        cmd_push = 1'b0;
        cmd_addr = '0;
        cmd_words = '0;
        halt = 1'b0;
        out_pop = 1'b0;
        err_addr = '0;
        err_hit = 1'b0;
        requested = 0;
        popped = 0;
        dropped = 0;
        done_cnt = 0;
        ar_cnt = 0;
        halt_prev = 1'b0;
        halt_allow = 1'b0;
        idx = 0;
        fd = $fopen("bench/dma_input.txt", "r");
        assert (fd != 0) else abort_run("cannot open bench/dma_input.txt");
        repeat (15) @(posedge clk);
        @(negedge clk);
        assert (!ar_valid && !r_ready && !cmd_done && !busy && error == 2'b00)
        else abort_run("outputs not idle during reset");
        @(posedge clk);
        #1;
        rst = 1'b0;

        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() < 8 || line[0] == "#") begin
                continue;
            end
            fields = $sscanf(line, "%h %h %h %d", addr, words, bad, stall);
            assert (fields == 4) else abort_run("malformed line in the input file");
            done_before = done_cnt;
            hs_before = ar_cnt;
            load_expect(addr, int'(words), bad);
            @(negedge clk);
            assert (cmd_almost_empty && !cmd_full)
            else abort_run("command queue not ready for a new command");
            @(posedge clk);
            #1;
            err_addr = bad;
            cmd_push = 1'b1;
            cmd_addr = addr;
            cmd_words = words;
            @(posedge clk);
            #1;
            cmd_push = 1'b0;
            // A queued command makes the engine busy
            if (words != '0) begin
                @(negedge clk);
                assert (busy) else abort_run($sformatf("error busy %h expected 1", busy));
            end
            fork
                consume_words(exp_data.size(), stall);
                begin
                    if (words != '0) begin
                        wait_done(done_before + 1);
                    end
                end
                begin
                    if (idx == halt_cmd) begin
                        pulse_halt(hs_before);
                    end
                end
            join
            wait_idle();
            repeat (2) @(negedge clk);
            assert (done_cnt == done_before + ((words != '0) ? 1 : 0))
            else abort_run($sformatf("error cmd_done count %h expected %h",
                                     done_cnt - done_before, (words != '0) ? 1 : 0));
            assert (exp_ar_addr.size() == 0) else abort_run("bursts missing on the read channel");
            assert (!out_valid) else abort_run("extra data left in the data buffer");
            assert (error == (err_hit ? 2'b10 : 2'b00))
            else abort_run($sformatf("error error %h expected %h", error, err_hit ? 2'b10 : 2'b00));
            idx++;
        end
        $fclose(fd);
        assert (idx > 0) else abort_run("no commands were run");
        $display(">>> PASS");
        $finish;
    end

endmodule

//--- dma_read_top.f
+incdir+source
source/dma_pkg.sv
source/dma_ifs.sv
source/dma_cmd_queue.sv
source/dma_burst_splitter.sv
source/dma_read_collector.sv
source/dma_data_buffer.sv
source/dma_read_top.sv
bench/axi_read_model.sv
bench/tb_dma_read.sv

//--- Makefile
SIM      = verilator
TOP      = tb_dma_read
RTL_TOP  = dma_read_top
FILELIST = dma_read_top.f
FLAGS    = --timing --assert
OBJ_DIR  = obj_dir

.PHONY: lint sim clean

lint:
	$(SIM) --lint-only $(FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(SIM) --binary $(FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '>>> PASS'

clean:
	rm -rf $(OBJ_DIR)

//--- bench/dma_input.txt
# start_addr word_count err_addr stall_pct
# hex        hex        hex      decimal, err_addr of zero means no error
00001000 0001 00000000 0
00002000 0011 00000000 10
00003004 0028 00000000 25
00004000 0000 00000000 0
00005000 0040 00000000 90
00006000 0064 00000000 75
00007ff0 0003 00000000 0
00008000 0025 00008040 20
